// ==== include/exec_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// execute cluster sizing, shared by the packages and every RTL block
// shift amount is taken from the low EXEC_SHAMT_W bits of src_b
//////////////////////////////////////////////////////////////////////

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// operand and result width
`define EXEC_XLEN 32

// reorder buffer entry index width
`define EXEC_ROB_W 4

// shift amount width, log2 of EXEC_XLEN
`define EXEC_SHAMT_W 5

`endif

// ==== verilog/isa_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// integer opcodes seen by the execute cluster
// the class function is the only place that maps an opcode to a unit
//////////////////////////////////////////////////////////////////////

package isa_pkg;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_slt  = 4'd5,
    op_sltu = 4'd6,
    op_sll  = 4'd7,
    op_srl  = 4'd8,
    op_sra  = 4'd9
  } alu_op_t;

  typedef enum logic {
    fu_alu   = 1'b0,
    fu_shift = 1'b1
  } fu_class_t;

  // shifts go to the iterative unit, everything else is single cycle
  function automatic fu_class_t fu_class_of(alu_op_t op);
    case (op)
      op_sll, op_srl, op_sra: return fu_shift;
      default:                return fu_alu;
    endcase
  endfunction

endpackage

// ==== verilog/exec_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// packet formats on the issue port, between the units and the CDB
// isa_pkg must be compiled first
//////////////////////////////////////////////////////////////////////

`include "exec_cfg.svh"

package exec_pkg;
  import isa_pkg::*;

  // one operation as it leaves the reservation station
  typedef struct packed {
    logic [`EXEC_ROB_W-1:0] rob_entry;
    alu_op_t                op;
    logic [`EXEC_XLEN-1:0]  src_a;
    logic [`EXEC_XLEN-1:0]  src_b;
  } issue_packet_t;

  // finished result held by a unit until the arbiter takes it
  typedef struct packed {
    logic [`EXEC_ROB_W-1:0] dest_rob_entry;
    logic [`EXEC_XLEN-1:0]  result;
  } fu_result_t;

  // broadcast beat, valid only in a cycle with a grant
  typedef struct packed {
    logic                   valid;
    logic [`EXEC_ROB_W-1:0] dest_rob_entry;
    logic [`EXEC_XLEN-1:0]  result;
  } cdb_packet_t;

endpackage

// ==== verilog/issue_router.sv ====
//////////////////////////////////////////////////////////////////////
// steers the issue valid to the unit that owns the opcode class
// issue_ready depends on the presented opcode, so the issuer holds
// the packet stable until the transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module issue_router
  import isa_pkg::*, exec_pkg::*;
(
  input  issue_packet_t issue,
  input  logic          issue_valid,
  output logic          issue_ready,

  output logic          alu_valid,
  input  logic          alu_ready,

  output logic          shift_valid,
  input  logic          shift_ready
);

  fu_class_t cls;

  assign cls = fu_class_of(issue.op);

  always_comb begin
    alu_valid   = 1'b0;
    shift_valid = 1'b0;
    case (cls)
      fu_shift: begin
        shift_valid = issue_valid;
        // a busy shifter only blocks shift opcodes
        issue_ready = shift_ready;
      end
      default: begin
        alu_valid   = issue_valid;
        issue_ready = alu_ready;
      end
    endcase
  end

endmodule

// ==== verilog/alu_unit.sv ====
//////////////////////////////////////////////////////////////////////
// single cycle integer ALU with one output holding register
// accepts a new operation in the cycle its held result is taken,
// so back to back issue runs at one per clock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module alu_unit
  import isa_pkg::*, exec_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  issue_packet_t in,
  input  logic          valid_in,
  output logic          ready,

  output logic          done,
  output fu_result_t    res,
  input  logic          yumi
);

  logic                  full;
  logic                  accept;
  logic [`EXEC_XLEN-1:0] result;

  assign ready  = !full || yumi;
  assign accept = valid_in && ready;
  assign done   = full;

  always_comb begin
    case (in.op)
      op_add:  result = in.src_a + in.src_b;
      op_sub:  result = in.src_a - in.src_b;
      op_and:  result = in.src_a & in.src_b;
      op_or:   result = in.src_a | in.src_b;
      op_xor:  result = in.src_a ^ in.src_b;
      op_slt:  result = `EXEC_XLEN'($signed(in.src_a) < $signed(in.src_b));
      op_sltu: result = `EXEC_XLEN'(in.src_a < in.src_b);
      // shift opcodes never reach this unit
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (yumi) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res.dest_rob_entry <= in.rob_entry;
      res.result         <= result;
    end
  end

  // held result must not move while the CDB has not taken it
  assert property (@(posedge clk) disable iff (reset)
    (done && !yumi) |=> (done && $stable(res)));

endmodule

// ==== verilog/shift_unit.sv ====
//////////////////////////////////////////////////////////////////////
// iterative shifter, one bit per clock, one operation at a time
// shift by n takes one load edge and n shift edges, n = 0 skips
// the shift state; result is held until yumi
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module shift_unit
  import isa_pkg::*, exec_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  issue_packet_t in,
  input  logic          valid_in,
  output logic          ready,

  output logic          done,
  output fu_result_t    res,
  input  logic          yumi
);

  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_shift = 2'b10,
    st_done  = 2'b11
  } shift_state_t;

  shift_state_t               state;
  logic                       load;
  logic [`EXEC_SHAMT_W-1:0]   shamt_in;
  logic [`EXEC_SHAMT_W-1:0]   count;
  logic [`EXEC_XLEN-1:0]      value;
  alu_op_t                    op_q;
  logic [`EXEC_ROB_W-1:0]     rob_q;

  assign shamt_in = in.src_b[`EXEC_SHAMT_W-1:0];
  assign ready    = (state == st_idle);
  assign load     = ready && valid_in;
  assign done     = (state == st_done);

  assign res.dest_rob_entry = rob_q;
  assign res.result         = value;

  // datapath: operand, count and tag registers
  always_ff @(posedge clk) begin
    if (load) begin
      value <= in.src_a;
      count <= shamt_in;
      op_q  <= in.op;
      rob_q <= in.rob_entry;
    end else if (state == st_shift) begin
      case (op_q)
        op_sll:  value <= {value[`EXEC_XLEN-2:0], 1'b0};
        op_sra:  value <= {value[`EXEC_XLEN-1], value[`EXEC_XLEN-1:1]};
        default: value <= {1'b0, value[`EXEC_XLEN-1:1]};
      endcase
      count <= count - 1'b1;
    end
  end

  // control FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (valid_in) begin
            state <= (shamt_in == '0) ? st_done : st_shift;
          end
        end
        st_shift: begin
          // last shift happens on this edge
          if (count == `EXEC_SHAMT_W'(1)) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (yumi) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // an offer that is refused must stay up, unchanged, until taken
  assert property (@(posedge clk) disable iff (reset)
    (valid_in && !ready) |=> (valid_in && $stable(in)));

  // count falls every shift cycle and never wraps, which bounds the
  // stay in st_shift to 31 cycles
  assert property (@(posedge clk) disable iff (reset)
    (state == st_shift) |=>
      (state != st_shift) || (count < $past(count) && count != '0));

endmodule

// ==== verilog/cdb_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// two way round robin grant onto the common data bus
// the CDB never stalls; yumi is combinational from the done inputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module cdb_arbiter
  import isa_pkg::*, exec_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  input  logic        alu_done,
  input  fu_result_t  alu_res,
  output logic        alu_yumi,

  input  logic        shift_done,
  input  fu_result_t  shift_res,
  output logic        shift_yumi,

  output cdb_packet_t cdb
);

  // unit that wins when both ask
  fu_class_t prio;

  assign alu_yumi   = alu_done && (!shift_done || prio == fu_alu);
  assign shift_yumi = shift_done && (!alu_done || prio == fu_shift);

  // pointer moves past whoever was granted
  always_ff @(posedge clk) begin
    if (reset) begin
      prio <= fu_alu;
    end else if (alu_yumi) begin
      prio <= fu_shift;
    end else if (shift_yumi) begin
      prio <= fu_alu;
    end
  end

  always_comb begin
    cdb.valid = alu_yumi || shift_yumi;
    if (shift_yumi) begin
      cdb.dest_rob_entry = shift_res.dest_rob_entry;
      cdb.result         = shift_res.result;
    end else begin
      cdb.dest_rob_entry = alu_res.dest_rob_entry;
      cdb.result         = alu_res.result;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    !(alu_yumi && shift_yumi));

endmodule

// ==== verilog/exec_cluster.sv ====
//////////////////////////////////////////////////////////////////////
// integer execute cluster: issue router, ALU, shifter, CDB arbiter
// the issue packet fans out to both units; only valid is steered
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module exec_cluster
  import exec_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  input  issue_packet_t issue,
  input  logic          issue_valid,
  output logic          issue_ready,

  output cdb_packet_t   cdb
);

  logic       alu_valid;
  logic       alu_ready;
  logic       alu_done;
  logic       alu_yumi;
  fu_result_t alu_res;

  logic       shift_valid;
  logic       shift_ready;
  logic       shift_done;
  logic       shift_yumi;
  fu_result_t shift_res;

  issue_router u_router (
    .issue       (issue),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .alu_valid   (alu_valid),
    .alu_ready   (alu_ready),
    .shift_valid (shift_valid),
    .shift_ready (shift_ready)
  );

  alu_unit u_alu (
    .clk      (clk),
    .reset    (reset),
    .in       (issue),
    .valid_in (alu_valid),
    .ready    (alu_ready),
    .done     (alu_done),
    .res      (alu_res),
    .yumi     (alu_yumi)
  );

  shift_unit u_shift (
    .clk      (clk),
    .reset    (reset),
    .in       (issue),
    .valid_in (shift_valid),
    .ready    (shift_ready),
    .done     (shift_done),
    .res      (shift_res),
    .yumi     (shift_yumi)
  );

  cdb_arbiter u_arb (
    .clk        (clk),
    .reset      (reset),
    .alu_done   (alu_done),
    .alu_res    (alu_res),
    .alu_yumi   (alu_yumi),
    .shift_done (shift_done),
    .shift_res  (shift_res),
    .shift_yumi (shift_yumi),
    .cdb        (cdb)
  );

endmodule

// ==== bench/tb_exec_cluster.sv ====
//////////////////////////////////////////////////////////////////////
// directed testbench for the execute cluster
// ROB entries are handed out in turn and never reused while in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "exec_cfg.svh"

module tb_exec_cluster
  import isa_pkg::*, exec_pkg::*;
();

  typedef logic [`EXEC_XLEN-1:0] word_t;

  localparam int RESET_CYCLES = 3;
  localparam int ROB_N        = 1 << `EXEC_ROB_W;
  // alu 28, shifts 25, alu during shift 5, same cycle 5, random 200
  localparam int NUM_OPS      = 28 + 25 + 5 + 5 + 200;
  localparam int CYCLE_LIMIT  = 40 * NUM_OPS + RESET_CYCLES;

  logic          clk;
  logic          reset;
  issue_packet_t issue;
  logic          issue_valid;
  logic          issue_ready;
  cdb_packet_t   cdb;

  logic [31:0]            lfsr;
  int                     cycles = 0;
  int                     issued;
  int                     retired;
  string                  test_name;
  logic [`EXEC_ROB_W-1:0] next_rob;

  // scoreboard indexed by ROB entry
  logic                   pending    [ROB_N];
  word_t                  expected   [ROB_N];
  int                     retire_seq [ROB_N];

  exec_cluster u_dut (
    .clk         (clk),
    .reset       (reset),
    .issue       (issue),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .cdb         (cdb)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error in %s: expected %h, actual %h", name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // galois LFSR stepped once per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic word_t model_result(alu_op_t op, word_t a, word_t b);
    logic [`EXEC_SHAMT_W-1:0] sh;
    sh = b[`EXEC_SHAMT_W-1:0];
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_slt:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      op_sltu: return (a < b) ? word_t'(1) : word_t'(0);
      op_sll:  return a << sh;
      op_srl:  return a >> sh;
      op_sra:  return word_t'($signed(a) >>> sh);
      default: return '0;
    endcase
  endfunction

  // only shift opcodes are blocked by a busy shifter
  function automatic logic ready_while_shift_busy(alu_op_t op);
    return fu_class_of(op) == fu_alu;
  endfunction

  // present one operation at drive time and hold it until the transfer
  task automatic issue_op(input alu_op_t op, input word_t a, input word_t b);
    logic [`EXEC_ROB_W-1:0] rob;
    while (pending[next_rob]) begin
      @(posedge clk);
      #1;
    end
    rob             = next_rob;
    issue.rob_entry = rob;
    issue.op        = op;
    issue.src_a     = a;
    issue.src_b     = b;
    issue_valid     = 1'b1;
    @(negedge clk);
    while (!issue_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    issue_valid   = 1'b0;
    expected[rob] = model_result(op, a, b);
    pending[rob]  = 1'b1;
    issued        = issued + 1;
    next_rob      = next_rob + 1'b1;
  endtask

  task automatic wait_for_retire();
    while (retired != issued) begin
      @(posedge clk);
      #1;
    end
  endtask

  // every CDB beat must match an entry still in flight
  always @(negedge clk) begin
    if (!reset && cdb.valid) begin
      if (!pending[cdb.dest_rob_entry]) begin
        abort_run($sformatf("CDB beat for ROB entry %0d which is not in flight (%s)",
                            cdb.dest_rob_entry, test_name));
      end else begin
        check_value(test_name, expected[cdb.dest_rob_entry], cdb.result);
        pending[cdb.dest_rob_entry]    = 1'b0;
        retire_seq[cdb.dest_rob_entry] = retired;
        retired                        = retired + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout after %0d cycles in %s", cycles, test_name));
    end
  end

  task automatic idle_after_reset();
    test_name = "reset_state";
    issue.op  = op_add;
    @(negedge clk);
    check_value(test_name, word_t'(0), word_t'(cdb.valid));
    check_value(test_name, word_t'(1), word_t'(issue_ready));
    @(posedge clk);
    #1;
    issue.op = op_sll;
    @(negedge clk);
    check_value(test_name, word_t'(0), word_t'(cdb.valid));
    check_value(test_name, word_t'(1), word_t'(issue_ready));
    @(posedge clk);
    #1;
  endtask

  task automatic alu_edge_values();
    word_t edge_a [4];
    word_t edge_b [4];
    test_name = "alu_ops";
    edge_a = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    // pairs where signed and unsigned compares disagree
    edge_b = '{32'h0000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001};
    for (logic [3:0] o = 4'd0; o <= 4'd6; o++) begin
      for (int i = 0; i < 4; i++) begin
        issue_op(alu_op_t'(o), edge_a[i], edge_b[i]);
      end
    end
    wait_for_retire();
  endtask

  task automatic shift_amounts_and_busy();
    word_t   amounts [4];
    word_t   srcs [2];
    alu_op_t dirs [3];
    test_name = "shift_ops";
    amounts = '{32'd0, 32'd1, 32'd17, 32'd31};
    srcs    = '{32'h8765_4321, 32'h1234_5679};
    dirs    = '{op_sll, op_srl, op_sra};
    for (int d = 0; d < 3; d++) begin
      for (int s = 0; s < 2; s++) begin
        for (int k = 0; k < 4; k++) begin
          // upper bits of src_b must be ignored
          issue_op(dirs[d], srcs[s], amounts[k] | 32'ha5a5_a5a0);
        end
      end
    end
    wait_for_retire();
    test_name = "shift_busy_ready";
    issue_op(op_srl, 32'hc000_0001, 32'd17);
    issue.op = op_sra;
    @(negedge clk);
    check_value(test_name, word_t'(ready_while_shift_busy(op_sra)), word_t'(issue_ready));
    @(posedge clk);
    #1;
    issue.op = op_add;
    @(negedge clk);
    check_value(test_name, word_t'(ready_while_shift_busy(op_add)), word_t'(issue_ready));
    @(posedge clk);
    #1;
    wait_for_retire();
  endtask

  task automatic alu_during_long_shift();
    logic [`EXEC_ROB_W-1:0] shift_rob;
    logic [`EXEC_ROB_W-1:0] alu_rob [4];
    test_name = "alu_during_shift";
    shift_rob = next_rob;
    issue_op(op_sll, 32'h0000_0003, 32'd31);
    for (int i = 0; i < 4; i++) begin
      alu_rob[i] = next_rob;
      issue_op(op_sub, word_t'(i), 32'd100);
    end
    wait_for_retire();
    for (int i = 0; i < 4; i++) begin
      if (retire_seq[alu_rob[i]] > retire_seq[shift_rob]) begin
        abort_run("an ALU result reached the CDB after the long shift");
      end
    end
  endtask

  task automatic same_cycle_finish();
    test_name = "same_cycle_finish";
    // zero shift goes straight to done, then the ALU op follows
    issue_op(op_sra, 32'h8000_0000, 32'd0);
    issue_op(op_xor, 32'hffff_0000, 32'h0f0f_0f0f);
    wait_for_retire();
    // one step shift raises done after the same edge as the first ALU op
    issue_op(op_srl, 32'hf000_000f, 32'd1);
    issue_op(op_or, 32'h1234_0000, 32'h0000_5678);
    issue_op(op_and, 32'hdead_beef, 32'hffff_0000);
    wait_for_retire();
  endtask

  task automatic random_back_to_back();
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] b;
    test_name = "random_ops";
    for (int i = 0; i < 200; i++) begin
      bits = take_bits(4);
      a    = take_bits(32);
      b    = take_bits(32);
      issue_op(alu_op_t'(bits[3:0] % 4'd10), a, b);
    end
    wait_for_retire();
  endtask

  initial begin
    reset       = 1'b1;
    issue       = '0;
    issue_valid = 1'b0;
    lfsr        = 32'd39;
    issued      = 0;
    retired     = 0;
    next_rob    = '0;
    test_name   = "reset";
    for (int r = 0; r < ROB_N; r++) begin
      pending[r]    = 1'b0;
      expected[r]   = '0;
      retire_seq[r] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    idle_after_reset();
    alu_edge_values();
    shift_amounts_and_busy();
    alu_during_long_shift();
    same_cycle_finish();
    random_back_to_back();

    $display("Test passed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/issue_router.sv
verilog/alu_unit.sv
verilog/shift_unit.sv
verilog/cdb_arbiter.sv
verilog/exec_cluster.sv
bench/tb_exec_cluster.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the execute cluster testbench with Verilator
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_exec_cluster \
  -f all.f \
  -o sim_exec_cluster
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_exec_cluster
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
